//--- source/fpu_pkg.sv
package fpu_pkg;

  ////////////////////
  // opcodes and tags
  ////////////////////

  localparam int TAG_W = 4;                        // command tag width

  typedef logic [TAG_W-1:0] tag_t;

  typedef enum logic [3:0] {
    op_add, op_sub, op_mul,                        // arithmetic
    op_sgnj, op_sgnjn, op_sgnjx,                   // sign injection
    op_min, op_max,
    op_feq, op_flt, op_fle,                        // compares, result in flag
    op_fmv
  } fp_op_e;

  typedef enum logic [1:0] {
    sel_add  = 2'd0,
    sel_mul  = 2'd1,
    sel_misc = 2'd2
  } fu_sel_e;

  typedef struct packed {
    logic [31:0] data;                             // result word
    logic        flag;                             // compare outcome
    tag_t        tag;                              // tag of the command
  } fp_result_t;

  function automatic fu_sel_e fu_of(input fp_op_e op);
    case (op)
      op_add, op_sub: return sel_add;
      op_mul:         return sel_mul;
      default:        return sel_misc;             // everything single cycle
    endcase
  endfunction

  ////////////////////
  // float fields
  ////////////////////

  function automatic logic fp_sign(input logic [31:0] x);
    return x[31];
  endfunction

  function automatic logic [7:0] fp_exp(input logic [31:0] x);
    return x[30:23];
  endfunction

  // hidden bit restored, subnormals read as zero
  function automatic logic [23:0] fp_mant(input logic [31:0] x);
    return (x[30:23] == 8'd0) ? 24'd0 : {1'b1, x[22:0]};
  endfunction

  // n = hidden, 23 frac, guard, round, sticky
  function automatic logic [31:0] fp_round(input logic sign, input logic signed [9:0] e_in,
                                           input logic [26:0] n);
    logic              up;
    logic [24:0]       m;
    logic signed [9:0] e;
    up = n[2] & (n[1] | n[0] | n[3]);              // nearest, ties to even
    m  = {1'b0, n[26:3]} + 25'(up);
    e  = m[24] ? e_in + 10'sd1 : e_in;             // carry out of rounding
    if (e <= 0) return {sign, 31'd0};              // underflow flushes
    if (e >= 255) return {sign, 8'hff, 23'd0};     // overflow to inf
    return {sign, e[7:0], m[24] ? m[23:1] : m[22:0]};
  endfunction

endpackage

//--- source/fu_if.sv
`timescale 1ns/10ps

// dispatcher -> unit, four-phase req/ack
interface fu_issue_if import fpu_pkg::*; ();
  logic        req;
  logic        ack;
  fp_op_e      op;
  logic [31:0] a;
  logic [31:0] b;
  tag_t        tag;

  modport issuer (output req, op, a, b, tag, input ack);
  modport unit   (input req, op, a, b, tag, output ack);
endinterface

// unit -> arbiter, same four-phase rule
interface fu_result_if import fpu_pkg::*; ();
  logic       req;
  logic       ack;
  fp_result_t res;                                 // held stable while req high

  modport producer (output req, res, input ack);
  modport arbiter  (input req, res, output ack);
endinterface

//--- source/fpu_dispatch.sv
`timescale 1ns/10ps

module fpu_dispatch import fpu_pkg::*; (
  input  logic        g_clk,
  input  logic        rst,
  input  logic        cmd_req,
  input  fp_op_e      cmd_op,
  input  logic [31:0] cmd_a,
  input  logic [31:0] cmd_b,
  input  tag_t        cmd_tag,
  output logic        cmd_ack,
  fu_issue_if.issuer  add_port,
  fu_issue_if.issuer  mul_port,
  fu_issue_if.issuer  misc_port
);

  typedef enum logic [1:0] {st_idle, st_issue, st_done} disp_st_e;

  disp_st_e    state;
  fp_op_e      op_q;                               // latched command
  logic [31:0] a_q;
  logic [31:0] b_q;
  tag_t        tag_q;
  fu_sel_e     sel_q;                              // target unit
  logic [2:0]  issue_req;                          // one bit per unit
  logic [2:0]  unit_ack;
  logic        take;

  assign unit_ack = {misc_port.ack, mul_port.ack, add_port.ack};

  // new command only once target's previous ack is gone
  assign take = (state == st_idle) && cmd_req && !unit_ack[fu_of(cmd_op)];

  ////////////////////
  // handshake fsm
  ////////////////////

  always_ff @(posedge g_clk) begin
    if (rst) begin
      state     <= st_idle;
      issue_req <= '0;
      cmd_ack   <= 1'b0;
    end else begin
      case (state)
        st_idle: if (take) begin
          issue_req <= 3'b001 << fu_of(cmd_op);    // req on decoded unit
          state     <= st_issue;
        end
        st_issue: if (unit_ack[sel_q]) begin       // unit took operands
          issue_req <= '0;
          cmd_ack   <= 1'b1;
          state     <= st_done;
        end
        st_done: if (!cmd_req) begin               // source released
          cmd_ack <= 1'b0;
          state   <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge g_clk) begin
    if (take) begin
      op_q  <= cmd_op;
      a_q   <= cmd_a;
      b_q   <= cmd_b;
      tag_q <= cmd_tag;
      sel_q <= fu_of(cmd_op);
    end
  end

  // payload fans out, only req selects
  assign add_port.req  = issue_req[sel_add];
  assign add_port.op   = op_q;
  assign add_port.a    = a_q;
  assign add_port.b    = b_q;
  assign add_port.tag  = tag_q;
  assign mul_port.req  = issue_req[sel_mul];
  assign mul_port.op   = op_q;
  assign mul_port.a    = a_q;
  assign mul_port.b    = b_q;
  assign mul_port.tag  = tag_q;
  assign misc_port.req = issue_req[sel_misc];
  assign misc_port.op  = op_q;
  assign misc_port.a   = a_q;
  assign misc_port.b   = b_q;
  assign misc_port.tag = tag_q;

  a_one_issue: assert property (@(posedge g_clk) disable iff (rst)
    $onehot0({misc_port.req, mul_port.req, add_port.req}));

  // cmd_ack only answers a held request
  a_ack_on_req: assert property (@(posedge g_clk) disable iff (rst)
    $rose(cmd_ack) |-> $past(cmd_req));

endmodule

//--- source/fp_add_unit.sv
`timescale 1ns/10ps

module fp_add_unit import fpu_pkg::*; #(
  parameter int ADD_STAGES = 4
) (
  input  logic          g_clk,
  input  logic          rst,
  fu_issue_if.unit      issue,
  fu_result_if.producer result
);

  localparam int CNT_W = $clog2(ADD_STAGES);

  logic              busy;
  logic [CNT_W-1:0]  cnt;                          // cycles left to result req
  logic              take;
  logic              fire;
  logic              sa_q, sb_q;                   // b sign already flipped for sub
  logic [7:0]        ea_q, eb_q;
  logic [23:0]       ma_q, mb_q;
  tag_t              tag_q;
  logic              swap;
  logic              sx, sy;                       // x is the larger magnitude
  logic [7:0]        ex, ey, d;
  logic [23:0]       mx, my;
  logic [26:0]       y_ext, y_al;                  // with guard, round, sticky
  logic [27:0]       s;
  logic [4:0]        lz;
  logic [26:0]       n;
  logic signed [9:0] e_n;
  logic [31:0]       sum_word;

  assign take = !busy && issue.req && !issue.ack && !result.ack;
  assign fire = busy && !result.req && (cnt == '0);

  function automatic logic [4:0] lzc27(input logic [26:0] v);
    logic [4:0] cnt_z;
    logic       found;
    cnt_z = 5'd0;
    found = 1'b0;
    for (int i = 26; i >= 0; i--) begin
      if (v[i]) found = 1'b1;
      else if (!found) cnt_z = cnt_z + 5'd1;
    end
    return cnt_z;
  endfunction

  ////////////////////
  // handshakes
  ////////////////////

  always_ff @(posedge g_clk) begin
    if (rst) begin
      issue.ack  <= 1'b0;
      result.req <= 1'b0;
      busy       <= 1'b0;
      cnt        <= '0;
    end else begin
      if (issue.ack && !issue.req) issue.ack <= 1'b0;  // issuer let go
      if (take) begin
        issue.ack <= 1'b1;
        busy      <= 1'b1;
        cnt       <= CNT_W'(ADD_STAGES - 1);
      end else if (busy && !result.req) begin
        if (cnt == '0) result.req <= 1'b1;
        else cnt <= cnt - 1'b1;                    // pipeline depth
      end else if (result.req && result.ack) begin
        result.req <= 1'b0;                        // granted so free again
        busy       <= 1'b0;
      end
    end
  end

  always_ff @(posedge g_clk) begin
    if (take) begin
      sa_q  <= fp_sign(issue.a);
      sb_q  <= fp_sign(issue.b) ^ (issue.op == op_sub);
      ea_q  <= fp_exp(issue.a);
      eb_q  <= fp_exp(issue.b);
      ma_q  <= fp_mant(issue.a);
      mb_q  <= fp_mant(issue.b);
      tag_q <= issue.tag;
    end
    if (fire) result.res <= '{data: sum_word, flag: 1'b0, tag: tag_q};
  end

  ////////////////////
  // datapath
  ////////////////////

  always_comb begin
    swap = {eb_q, mb_q} > {ea_q, ma_q};
    sx   = swap ? sb_q : sa_q;
    sy   = swap ? sa_q : sb_q;
    ex   = swap ? eb_q : ea_q;
    ey   = swap ? ea_q : eb_q;
    mx   = swap ? mb_q : ma_q;
    my   = swap ? ma_q : mb_q;
    d    = ex - ey;
    y_ext = {my, 3'b000};
    if (d > 8'd26) y_al = {26'd0, |my};            // all in sticky
    else y_al = (y_ext >> d) | 27'(|(y_ext & ~({27{1'b1}} << d)));
    if (sx == sy) s = {1'b0, mx, 3'b000} + {1'b0, y_al};
    else s = {1'b0, mx, 3'b000} - {1'b0, y_al};   // never negative
    lz = lzc27(s[26:0]);
    if (s[27]) begin                               // carry out so shift right by one
      n   = {s[27:2], s[1] | s[0]};
      e_n = $signed({2'b00, ex}) + 10'sd1;
    end else begin
      n   = s[26:0] << lz;
      e_n = $signed({2'b00, ex}) - $signed({5'd0, lz});
    end
    // exact cancel gives +0
    if (s == '0) sum_word = {sx & sy, 31'd0};
    else sum_word = fp_round(sx, e_n, n);
  end

  // a new issue req only rises while ack is low
  a_req_ack_low: assert property (@(posedge g_clk) disable iff (rst)
    $rose(issue.req) |-> !issue.ack);

endmodule

//--- source/fp_mul_unit.sv
`timescale 1ns/10ps

module fp_mul_unit import fpu_pkg::*; #(
  parameter int MUL_STAGES = 3
) (
  input  logic          g_clk,
  input  logic          rst,
  fu_issue_if.unit      issue,
  fu_result_if.producer result
);

  localparam int CNT_W = $clog2(MUL_STAGES);

  logic              busy;
  logic [CNT_W-1:0]  cnt;
  logic              take;
  logic              fire;
  logic              s_q;                          // product sign
  logic [7:0]        ea_q, eb_q;
  logic [23:0]       ma_q, mb_q;
  tag_t              tag_q;
  logic [47:0]       p;
  logic [26:0]       n;
  logic signed [9:0] e_n;
  logic [31:0]       prod_word;

  assign take = !busy && issue.req && !issue.ack && !result.ack;
  assign fire = busy && !result.req && (cnt == '0);

  always_ff @(posedge g_clk) begin
    if (rst) begin
      issue.ack  <= 1'b0;
      result.req <= 1'b0;
      busy       <= 1'b0;
      cnt        <= '0;
    end else begin
      if (issue.ack && !issue.req) issue.ack <= 1'b0;
      if (take) begin
        issue.ack <= 1'b1;
        busy      <= 1'b1;
        cnt       <= CNT_W'(MUL_STAGES - 1);
      end else if (busy && !result.req) begin
        if (cnt == '0) result.req <= 1'b1;
        else cnt <= cnt - 1'b1;
      end else if (result.req && result.ack) begin
        result.req <= 1'b0;
        busy       <= 1'b0;
      end
    end
  end

  always_ff @(posedge g_clk) begin
    if (take) begin
      s_q   <= fp_sign(issue.a) ^ fp_sign(issue.b);
      ea_q  <= fp_exp(issue.a);
      eb_q  <= fp_exp(issue.b);
      ma_q  <= fp_mant(issue.a);
      mb_q  <= fp_mant(issue.b);
      tag_q <= issue.tag;
    end
    if (fire) result.res <= '{data: prod_word, flag: 1'b0, tag: tag_q};
  end

  ////////////////////
  // datapath
  ////////////////////

  always_comb begin
    p = ma_q * mb_q;                               // 1.x * 1.x in [1,4)
    if (p[47]) n = {p[47:22], |p[21:0]};           // normalize by one
    else n = {p[46:21], |p[20:0]};
    e_n = $signed({2'b00, ea_q}) + $signed({2'b00, eb_q}) - 10'sd127
          + $signed({9'd0, p[47]});
    if (ma_q == '0 || mb_q == '0) prod_word = {s_q, 31'd0};  // zero operand
    else prod_word = fp_round(s_q, e_n, n);
  end

endmodule

//--- source/fp_misc_unit.sv
`timescale 1ns/10ps

module fp_misc_unit import fpu_pkg::*; (
  input  logic          g_clk,
  input  logic          rst,
  fu_issue_if.unit      issue,
  fu_result_if.producer result
);

  logic        busy;
  logic        take;
  logic        fire;
  fp_op_e      op_q;
  logic [31:0] a_q, b_q;
  tag_t        tag_q;
  logic [31:0] a_key, b_key;                       // total order keys
  logic        lt, eq;
  logic [31:0] data;
  logic        flag;

  assign take = !busy && issue.req && !issue.ack && !result.ack;
  assign fire = busy && !result.req;               // one cycle after capture

  // sign-magnitude to unsigned order, -0 sits below +0
  function automatic logic [31:0] ord_key(input logic [31:0] x);
    return fp_sign(x) ? ~x : (x ^ 32'h8000_0000);
  endfunction

  always_ff @(posedge g_clk) begin
    if (rst) begin
      issue.ack  <= 1'b0;
      result.req <= 1'b0;
      busy       <= 1'b0;
    end else begin
      if (issue.ack && !issue.req) issue.ack <= 1'b0;
      if (take) begin
        issue.ack <= 1'b1;
        busy      <= 1'b1;
      end else if (fire) result.req <= 1'b1;
      else if (result.req && result.ack) begin
        result.req <= 1'b0;
        busy       <= 1'b0;
      end
    end
  end

  always_ff @(posedge g_clk) begin
    if (take) begin
      op_q  <= issue.op;
      a_q   <= issue.a;
      b_q   <= issue.b;
      tag_q <= issue.tag;
    end
    if (fire) result.res <= '{data: data, flag: flag, tag: tag_q};
  end

  assign a_key = ord_key(a_q);
  assign b_key = ord_key(b_q);
  assign lt    = a_key < b_key;
  assign eq    = a_key == b_key;

  always_comb begin
    data = a_q;                                    // fmv and default
    flag = 1'b0;
    case (op_q)
      op_sgnj:  data = {fp_sign(b_q), a_q[30:0]};
      op_sgnjn: data = {~fp_sign(b_q), a_q[30:0]};
      op_sgnjx: data = {fp_sign(a_q) ^ fp_sign(b_q), a_q[30:0]};
      op_min:   data = lt ? a_q : b_q;
      op_max:   data = lt ? b_q : a_q;
      op_feq: begin data = '0; flag = eq; end
      op_flt: begin data = '0; flag = lt; end
      op_fle: begin data = '0; flag = lt | eq; end
      default:  data = a_q;
    endcase
  end

endmodule

//--- source/result_arbiter.sv
`timescale 1ns/10ps

module result_arbiter import fpu_pkg::*; #(
  parameter int N_UNITS = 3
) (
  input  logic         g_clk,
  input  logic         rst,
  fu_result_if.arbiter src [N_UNITS],
  output logic         out_valid,
  output logic [31:0]  out_data,
  output logic         out_flag,
  output tag_t         out_tag
);

  localparam int PTR_W = (N_UNITS > 1) ? $clog2(N_UNITS) : 1;

  logic [N_UNITS-1:0] req_vec;
  logic [N_UNITS-1:0] ack_q;                       // held until req drops
  logic [N_UNITS-1:0] grant;
  logic [PTR_W-1:0]   gidx;
  logic [PTR_W-1:0]   last_q;                      // last granted unit
  fp_result_t         res_arr [N_UNITS];

  for (genvar i = 0; i < N_UNITS; i++) begin : g_src
    assign req_vec[i] = src[i].req;
    assign res_arr[i] = src[i].res;
    assign src[i].ack = ack_q[i];
  end

  ////////////////////
  // round robin pick
  ////////////////////

  always_comb begin
    int idx;
    grant = '0;
    gidx  = '0;
    for (int k = 1; k <= N_UNITS; k++) begin       // search after last grant
      idx = (int'(last_q) + k) % N_UNITS;
      if (grant == '0 && ack_q == '0 && req_vec[idx]) begin
        grant[idx] = 1'b1;
        gidx       = PTR_W'(idx);
      end
    end
  end

  always_ff @(posedge g_clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      ack_q     <= '0;
      last_q    <= PTR_W'(N_UNITS - 1);            // unit 0 first
    end else begin
      out_valid <= |grant;                         // single cycle pulse
      if (|grant) begin
        ack_q  <= grant;
        last_q <= gidx;
      end else begin
        ack_q <= ack_q & req_vec;                  // drop after req falls
      end
    end
  end

  always_ff @(posedge g_clk) begin
    if (|grant) begin
      out_data <= res_arr[gidx].data;
      out_flag <= res_arr[gidx].flag;
      out_tag  <= res_arr[gidx].tag;
    end
  end

  a_grant_onehot: assert property (@(posedge g_clk) disable iff (rst)
    $onehot0(grant));

endmodule

//--- source/fpu_top.sv
`timescale 1ns/10ps

module fpu_top import fpu_pkg::*; #(
  parameter int ADD_STAGES = 4,
  parameter int MUL_STAGES = 3
) (
  input  logic        g_clk,
  input  logic        rst,
  input  logic        cmd_req,
  input  fp_op_e      cmd_op,
  input  logic [31:0] cmd_a,
  input  logic [31:0] cmd_b,
  input  tag_t        cmd_tag,
  output logic        cmd_ack,
  output logic        out_valid,
  output logic [31:0] out_data,
  output logic        out_flag,
  output tag_t        out_tag
);

  localparam int N_UNITS = 3;                      // add, mul, misc

  fu_issue_if  add_iss ();
  fu_issue_if  mul_iss ();
  fu_issue_if  misc_iss ();
  fu_result_if res_link [N_UNITS] ();              // 0 add, 1 mul, 2 misc

  fpu_dispatch u_dispatch (
    .g_clk     (g_clk),
    .rst       (rst),
    .cmd_req   (cmd_req),
    .cmd_op    (cmd_op),
    .cmd_a     (cmd_a),
    .cmd_b     (cmd_b),
    .cmd_tag   (cmd_tag),
    .cmd_ack   (cmd_ack),
    .add_port  (add_iss),
    .mul_port  (mul_iss),
    .misc_port (misc_iss)
  );

  fp_add_unit #(.ADD_STAGES(ADD_STAGES)) u_add (
    .g_clk (g_clk), .rst (rst), .issue (add_iss), .result (res_link[0])
  );

  fp_mul_unit #(.MUL_STAGES(MUL_STAGES)) u_mul (
    .g_clk (g_clk), .rst (rst), .issue (mul_iss), .result (res_link[1])
  );

  fp_misc_unit u_misc (
    .g_clk (g_clk), .rst (rst), .issue (misc_iss), .result (res_link[2])
  );

  result_arbiter #(.N_UNITS(N_UNITS)) u_arb (
    .g_clk     (g_clk),
    .rst       (rst),
    .src       (res_link),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_flag  (out_flag),
    .out_tag   (out_tag)
  );

endmodule

//--- bench/fpu_ref.svh
`ifndef FPU_REF_SVH
`define FPU_REF_SVH

// single bits to double, normals only
function automatic real single_to_real(input logic [31:0] x);
  logic [63:0] d;
  if (x[30:23] == 8'd0) return 0.0;                // flushed input
  d = {x[31], 11'(int'(x[30:23]) - 127 + 1023), x[22:0], 29'd0};
  return $bitstoreal(d);
endfunction

// double back to single, nearest even, range kept normal by stimulus
function automatic logic [31:0] real_to_single(input real r);
  logic [63:0] d;
  logic [24:0] m;
  logic        up;
  int          e;
  d = $realtobits(r);
  if (d[62:0] == 63'd0) return {d[63], 31'd0};    // exact zero keeps its sign
  e  = int'(d[62:52]) - 1023 + 127;
  up = d[28] & (d[29] | (|d[27:0]));              // guard and (lsb or sticky)
  m  = {2'b01, d[51:29]} + 25'(up);
  if (m[24]) begin                                 // rounded up to next binade
    e = e + 1;
    m = m >> 1;
  end
  return {d[63], 8'(e), m[22:0]};
endfunction

// ordered less-than, -0 below +0
function automatic logic ref_lt(input logic [31:0] a, input logic [31:0] b);
  if (a[31] != b[31]) return a[31];
  if (a[31]) return a[30:0] > b[30:0];             // both negative, larger mag is lower
  return a[30:0] < b[30:0];
endfunction

// expected {data, flag} for one command
function automatic logic [32:0] ref_result(input fp_op_e op, input logic [31:0] a,
                                           input logic [31:0] b);
  real         ra;
  real         rb;
  logic [31:0] data;
  logic        flag;
  ra   = single_to_real(a);
  rb   = single_to_real(b);
  data = '0;
  flag = 1'b0;
  case (op)
    op_add:   data = real_to_single(ra + rb);
    op_sub:   data = real_to_single(ra - rb);
    op_mul:   data = real_to_single(ra * rb);
    op_sgnj:  data = {b[31], a[30:0]};
    op_sgnjn: data = {~b[31], a[30:0]};
    op_sgnjx: data = {a[31] ^ b[31], a[30:0]};
    op_min:   data = ref_lt(b, a) ? b : a;
    op_max:   data = ref_lt(a, b) ? b : a;
    op_feq:   flag = (a == b);                     // compares leave data zero
    op_flt:   flag = ref_lt(a, b);
    op_fle:   flag = ref_lt(a, b) || (a == b);
    op_fmv:   data = a;
    default:  data = '0;
  endcase
  return {data, flag};
endfunction

`endif

//--- bench/fpu_tb.sv
`timescale 1ns/10ps

module fpu_tb import fpu_pkg::*; ();

  localparam int N_RAND     = 200;
  localparam int N_DIRECTED = 22;
  localparam int N_TAGS     = 2 ** TAG_W;
  localparam int RST_CYCLES = 10;
  localparam int LIMIT      = (N_RAND + N_DIRECTED) * 40 + RST_CYCLES;
  localparam logic [31:0] P_ZERO = 32'h0000_0000;
  localparam logic [31:0] N_ZERO = 32'h8000_0000;
  localparam logic [31:0] ONE_5  = 32'h3fc0_0000;   // 1.5
  localparam logic [31:0] M_TWO  = 32'hc000_0000;   // -2.0
  localparam logic [31:0] PI_F   = 32'h4049_0fdb;

  logic        g_clk, rst;
  logic        cmd_req, cmd_ack;
  fp_op_e      cmd_op;
  logic [31:0] cmd_a, cmd_b;
  tag_t        cmd_tag;
  logic        out_valid, out_flag;
  logic [31:0] out_data;
  tag_t        out_tag;

  integer            seed = 23;
  int                data_errs, tag_errs, proto_errs;
  logic [N_TAGS-1:0] pending;                       // tags in flight
  logic [31:0]       exp_data [N_TAGS];
  logic              exp_flag [N_TAGS];
  fp_op_e            exp_op [N_TAGS];
  tag_t              next_tag;

  `include "fpu_ref.svh"

  fpu_top #(.ADD_STAGES(4), .MUL_STAGES(3)) UUT (
    .g_clk (g_clk), .rst (rst),
    .cmd_req (cmd_req), .cmd_op (cmd_op), .cmd_a (cmd_a), .cmd_b (cmd_b),
    .cmd_tag (cmd_tag), .cmd_ack (cmd_ack),
    .out_valid (out_valid), .out_data (out_data), .out_flag (out_flag), .out_tag (out_tag)
  );

  initial begin
    g_clk = 1'b0;
    forever #50 g_clk = ~g_clk;                     // 100 ns period
  end

  // normal operand with exponent 100..154
  function automatic logic [31:0] rand_float();
    logic [31:0] r;
    int unsigned e;
    r = $random(seed);
    e = 100 + ({$random(seed)} % 55);
    return {r[31], 8'(e), r[22:0]};
  endfunction

  task automatic alloc_tag(output tag_t t);
    while (&pending) @(negedge g_clk);
    while (pending[next_tag]) next_tag = next_tag + 1'b1;  // skip busy tags
    t        = next_tag;
    next_tag = next_tag + 1'b1;
  endtask

  // four-phase command started on a falling edge
  task automatic send_cmd(input fp_op_e op, input logic [31:0] a, input logic [31:0] b,
                          output tag_t t, output logic [N_TAGS-1:0] pend_at_ack);
    logic [32:0] exp_r;
    alloc_tag(t);
    exp_r      = ref_result(op, a, b);
    exp_data[t] = exp_r[32:1];
    exp_flag[t] = exp_r[0];
    exp_op[t]   = op;
    pending[t]  = 1'b1;
    cmd_op  = op;
    cmd_a   = a;
    cmd_b   = b;
    cmd_tag = t;
    cmd_req = 1'b1;
    @(negedge g_clk);
    while (!cmd_ack) @(negedge g_clk);
    pend_at_ack = pending;                          // snapshot for back-pressure
    cmd_req     = 1'b0;
    @(negedge g_clk);
    while (cmd_ack) @(negedge g_clk);
  endtask

  task automatic send_op(input fp_op_e op, input logic [31:0] a, input logic [31:0] b);
    tag_t              t;
    logic [N_TAGS-1:0] p;
    send_cmd(op, a, b, t, p);
  endtask

  task automatic check_idle(input string when_s);
    assert (out_valid === 1'b0 && cmd_ack === 1'b0) else begin
      proto_errs++;
      $display("out_valid or cmd_ack not low %s at %0t", when_s, $time);
    end
  endtask

  ////////////////////
  // test groups
  ////////////////////

  task automatic run_directed();
    send_op(op_sgnj, ONE_5, M_TWO);
    send_op(op_sgnjn, ONE_5, M_TWO);
    send_op(op_sgnjx, ONE_5 | N_ZERO, M_TWO);
    send_op(op_sgnjx, ONE_5, PI_F);
    send_op(op_fmv, PI_F, M_TWO);
    send_op(op_min, N_ZERO, P_ZERO);                // signed zeros
    send_op(op_max, N_ZERO, P_ZERO);
    send_op(op_min, P_ZERO, N_ZERO);
    send_op(op_feq, N_ZERO, P_ZERO);
    send_op(op_flt, N_ZERO, P_ZERO);
    send_op(op_fle, P_ZERO, N_ZERO);
    send_op(op_feq, PI_F, PI_F);                    // equal operands
    send_op(op_fle, PI_F, PI_F);
    send_op(op_flt, PI_F, PI_F);
    send_op(op_max, M_TWO, 32'hbf80_0000);
    send_op(op_sub, PI_F, PI_F);                    // x - x is +0
    send_op(op_add, PI_F, PI_F | N_ZERO);
    send_op(op_sub, 32'h3f80_0001, 32'h3f80_0000);  // heavy cancel
    send_op(op_add, 32'h3f80_0000, 32'hbf7f_ffff);
    send_op(op_mul, ONE_5, 32'hc040_0000);
  endtask

  task automatic run_back_pressure();
    tag_t              t1, t2;
    logic [N_TAGS-1:0] p1, p2;
    send_cmd(op_mul, rand_float(), rand_float(), t1, p1);
    send_cmd(op_mul, rand_float() | N_ZERO, rand_float(), t2, p2);
    assert (!p2[t1]) else begin
      proto_errs++;
      $display("second multiply acknowledged before first result at %0t", $time);
    end
  endtask

  task automatic run_random();
    logic [31:0] a, b, r;
    fp_op_e      op;
    int          mode;
    for (int i = 0; i < N_RAND; i++) begin
      op   = fp_op_e'(4'({$random(seed)} % 12));
      a    = rand_float();
      r    = $random(seed);
      mode = {$random(seed)} % 4;
      if (mode == 0) b = {a[31] ^ r[8], a[30:8], r[7:0]};   // near equal so it cancels
      else if (mode == 1) b = a;
      else b = rand_float();
      send_op(op, a, b);
    end
  endtask

  ////////////////////
  // result compare
  ////////////////////

  always @(negedge g_clk) begin
    if (!rst && out_valid) begin
      assert (pending[out_tag]) else begin
        tag_errs++;
        $display("unexpected or duplicate result tag %0d at %0t", out_tag, $time);
      end
      if (pending[out_tag]) begin
        assert (out_data === exp_data[out_tag] && out_flag === exp_flag[out_tag]) else begin
          data_errs++;
          $display("error at %0t: tag %0d %s gave %h flag %b, expected %h flag %b",
                   $time, out_tag, exp_op[out_tag].name(), out_data, out_flag,
                   exp_data[out_tag], exp_flag[out_tag]);
        end
        pending[out_tag] = 1'b0;                    // tag free again
      end
    end
  end

  initial begin
    rst        = 1'b1;
    cmd_req    = 1'b0;
    cmd_op     = op_add;
    cmd_a      = '0;
    cmd_b      = '0;
    cmd_tag    = '0;
    pending    = '0;
    next_tag   = '0;
    data_errs  = 0;
    tag_errs   = 0;
    proto_errs = 0;
    repeat (RST_CYCLES) begin
      @(negedge g_clk);
      check_idle("during reset");
    end
    rst = 1'b0;
    repeat (3) begin
      @(negedge g_clk);
      check_idle("after reset");
    end
    run_directed();
    run_back_pressure();
    run_random();
    while (pending != '0) @(negedge g_clk);         // drain outstanding tags
    $display("errors: %0d wrong values, %0d bad tags, %0d protocol",
             data_errs, tag_errs, proto_errs);
    if (data_errs + tag_errs + proto_errs == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  // watchdog
  initial begin
    repeat (LIMIT) @(posedge g_clk);
    $display("timeout: run did not finish within %0d cycles", LIMIT);
    $display("Finished with errors");
    $finish;
  end

endmodule

//--- all.f
+incdir+bench
source/fpu_pkg.sv
source/fu_if.sv
source/fpu_dispatch.sv
source/fp_add_unit.sv
source/fp_mul_unit.sv
source/fp_misc_unit.sv
source/result_arbiter.sv
source/fpu_top.sv
bench/fpu_tb.sv
